//--- Makefile
SIM := obj_dir/bridgeSim

.PHONY: all run clean

all: run

$(SIM): sim.f $(shell cat sim.f)
	verilator --binary --timing -f sim.f --top-module bridgeTb -o bridgeSim

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir

//--- common/axiPkg.sv
`default_nettype none

package axiPkg;

    typedef logic [31:0] addrT;
    typedef logic [3:0]  idT;
    typedef logic [3:0]  lenT;
    typedef logic [2:0]  sizeT;
    typedef logic [1:0]  burstT;

    // instruction fetches and data reads are told apart by their read id
    localparam idT instId = 4'd0;
    localparam idT dataId = 4'd1;

    localparam lenT lineLen   = 4'd3;  // four beats per instruction line
    localparam lenT singleLen = 4'd0;

    localparam addrT lineAlignMask = 32'hffff_fff0;

    // the bridge always moves one 32-bit word per beat on an incrementing burst
    localparam sizeT  beatSize  = 3'b010;
    localparam burstT incrBurst = 2'b01;

endpackage

`default_nettype wire

//--- common/bridgePkg.sv
`default_nettype none

package bridgePkg;

    typedef logic [31:0]  wordT;
    typedef logic [127:0] lineT;
    typedef logic [3:0]   strobeT;

    localparam int beatsPerLine = 4;

    typedef logic [$clog2(beatsPerLine)-1:0] beatIdxT;

    typedef enum logic [1:0] {
        rdIdle,
        rdData,
        rdInst,
        rdLineOut
    } readStateT;

    typedef enum logic [1:0] {
        wrIdle,
        wrAddr,
        wrData,
        wrResp
    } writeStateT;

endpackage

`default_nettype wire

//--- common/dataReqIf.sv
`default_nettype none

interface dataReqIf;
    import axiPkg::*;
    import bridgePkg::*;

    logic   readPending;
    logic   writePending;
    addrT   addr;
    wordT   wData;
    strobeT strobe;
    logic   readDone;
    logic   writeDone;

    modport slot(output readPending, writePending, addr, wData, strobe,
                 input readDone, writeDone);
    modport reader(input readPending, addr, output readDone);
    modport writer(input writePending, addr, wData, strobe, output writeDone);

endinterface

`default_nettype wire

//--- design/axiBridge.sv
`default_nettype none

module axiBridge (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    instReqValid,
    input  wire axiPkg::addrT      instReqPc,
    output logic                   instReqReady,
    output logic                   instRespValid,
    output bridgePkg::lineT        instRespLine,
    input  wire                    instRespReady,
    input  wire                    dataReqValid,
    input  wire axiPkg::addrT      dataReqAddr,
    input  wire bridgePkg::wordT   dataReqWData,
    input  wire                    dataReqWEn,
    input  wire bridgePkg::strobeT dataReqStrobe,
    output logic                   dataReqReady,
    output logic                   dataRespValid,
    output bridgePkg::wordT        dataRespData,
    input  wire                    dataRespReady,
    output logic                   arValid,
    input  wire                    arReady,
    output axiPkg::idT             arId,
    output axiPkg::addrT           arAddr,
    output axiPkg::lenT            arLen,
    input  wire                    rValid,
    input  wire bridgePkg::wordT   rData,
    input  wire                    rLast,
    output logic                   rReady,
    output logic                   awValid,
    input  wire                    awReady,
    output axiPkg::addrT           awAddr,
    output logic                   wValid,
    input  wire                    wReady,
    output bridgePkg::wordT        wData,
    output bridgePkg::strobeT      wStrb,
    input  wire                    bValid,
    output logic                   bReady
);

    dataReqIf dataReq();

    dataReqSlot dataReqSlot_inst (
        .clk           (clk),
        .rst           (rst),
        .dataReqValid  (dataReqValid),
        .dataReqAddr   (dataReqAddr),
        .dataReqWData  (dataReqWData),
        .dataReqWEn    (dataReqWEn),
        .dataReqStrobe (dataReqStrobe),
        .dataReqReady  (dataReqReady),
        .req           (dataReq.slot)
    );

    readEngine readEngine_inst (
        .clk           (clk),
        .rst           (rst),
        .instReqValid  (instReqValid),
        .instReqPc     (instReqPc),
        .instReqReady  (instReqReady),
        .instRespValid (instRespValid),
        .instRespLine  (instRespLine),
        .instRespReady (instRespReady),
        .dataRespValid (dataRespValid),
        .dataRespData  (dataRespData),
        .dataRespReady (dataRespReady),
        .req           (dataReq.reader),
        .arValid       (arValid),
        .arReady       (arReady),
        .arId          (arId),
        .arAddr        (arAddr),
        .arLen         (arLen),
        .rValid        (rValid),
        .rData         (rData),
        .rLast         (rLast),
        .rReady        (rReady)
    );

    writeEngine writeEngine_inst (
        .clk     (clk),
        .rst     (rst),
        .req     (dataReq.writer),
        .awValid (awValid),
        .awReady (awReady),
        .awAddr  (awAddr),
        .wValid  (wValid),
        .wReady  (wReady),
        .wData   (wData),
        .wStrb   (wStrb),
        .bValid  (bValid),
        .bReady  (bReady)
    );

endmodule

`default_nettype wire

//--- design/dataReqSlot.sv
`default_nettype none

module dataReqSlot (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    dataReqValid,
    input  wire axiPkg::addrT      dataReqAddr,
    input  wire bridgePkg::wordT   dataReqWData,
    input  wire                    dataReqWEn,
    input  wire bridgePkg::strobeT dataReqStrobe,
    output logic                   dataReqReady,
    dataReqIf.slot                 req
);
    import axiPkg::*;
    import bridgePkg::*;

    logic   held;
    logic   heldWrite;
    addrT   addrQ;
    wordT   wDataQ;
    strobeT strobeQ;

    assign dataReqReady = !held;

    always_ff @(posedge clk) begin
        if (rst) begin
            held      <= 1'b0;
            heldWrite <= 1'b0;
        end else if (dataReqValid && dataReqReady) begin
            held      <= 1'b1;
            heldWrite <= dataReqWEn;
        end else if (req.readDone || req.writeDone) begin
            held <= 1'b0;  // only one engine can own the request at a time
        end
    end

    always_ff @(posedge clk) begin
        if (dataReqValid && dataReqReady) begin
            addrQ   <= dataReqAddr;
            wDataQ  <= dataReqWData;
            strobeQ <= dataReqStrobe;
        end
    end

    assign req.readPending  = held && !heldWrite;
    assign req.writePending = held && heldWrite;
    assign req.addr         = addrQ;
    assign req.wData        = wDataQ;
    assign req.strobe       = strobeQ;

endmodule

`default_nettype wire

//--- design/readEngine.sv
`default_nettype none

module readEngine (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  instReqValid,
    input  wire axiPkg::addrT    instReqPc,
    output logic                 instReqReady,
    output logic                 instRespValid,
    output bridgePkg::lineT      instRespLine,
    input  wire                  instRespReady,
    output logic                 dataRespValid,
    output bridgePkg::wordT      dataRespData,
    input  wire                  dataRespReady,
    dataReqIf.reader             req,
    output logic                 arValid,
    input  wire                  arReady,
    output axiPkg::idT           arId,
    output axiPkg::addrT         arAddr,
    output axiPkg::lenT          arLen,
    input  wire                  rValid,
    input  wire bridgePkg::wordT rData,
    input  wire                  rLast,
    output logic                 rReady
);
    import axiPkg::*;
    import bridgePkg::*;

    readStateT state;
    logic      instHeld;
    addrT      instPc;
    logic      arHold;
    logic      holdData;
    logic      pickData;
    beatIdxT   beatIdx;
    lineT      line;
    logic      rFire;

    assign instReqReady = !instHeld;

    always_ff @(posedge clk) begin
        if (rst) begin
            instHeld <= 1'b0;
        end else if (instReqValid && instReqReady) begin
            instHeld <= 1'b1;
        end else if (state == rdLineOut && instRespReady) begin
            instHeld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instReqValid && instReqReady) begin
            instPc <= instReqPc;
        end
    end

    // once an AR is offered its choice is frozen so the address stays stable while stalled
    assign pickData = arHold ? holdData : req.readPending;

    always_ff @(posedge clk) begin
        if (rst) begin
            arHold <= 1'b0;
        end else begin
            arHold <= arValid && !arReady;
        end
        holdData <= pickData;
    end

    assign arValid = (state == rdIdle) && (req.readPending || instHeld);
    assign arId    = pickData ? dataId : instId;
    assign arAddr  = pickData ? req.addr : (instPc & lineAlignMask);
    assign arLen   = pickData ? singleLen : lineLen;

    assign rReady        = (state == rdInst) || (state == rdData && dataRespReady);
    assign rFire         = rValid && rReady;
    assign dataRespValid = (state == rdData) && rValid;
    assign dataRespData  = rData;
    assign req.readDone  = (state == rdData) && rFire;
    assign instRespValid = (state == rdLineOut);
    assign instRespLine  = line;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rdIdle;
        end else begin
            case (state)
                rdIdle: begin
                    if (arValid && arReady) begin
                        state <= pickData ? rdData : rdInst;
                    end
                end
                rdData: begin
                    if (rFire) begin
                        state <= rdIdle;
                    end
                end
                rdInst: begin
                    if (rFire && rLast) begin
                        state <= rdLineOut;
                    end
                end
                rdLineOut: begin
                    if (instRespReady) begin
                        state <= rdIdle;
                    end
                end
                default: state <= rdIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beatIdx <= '0;
        end else if (state == rdInst && rFire) begin
            beatIdx <= beatIdx + 1'b1;
        end else if (state == rdIdle) begin
            beatIdx <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == rdInst && rFire) begin
            line[beatIdx * $bits(wordT) +: $bits(wordT)] <= rData;  // lowest address lands lowest
        end
    end

endmodule

`default_nettype wire

//--- design/writeEngine.sv
`default_nettype none

module writeEngine (
    input  wire         clk,
    input  wire         rst,
    dataReqIf.writer    req,
    output logic        awValid,
    input  wire         awReady,
    output axiPkg::addrT awAddr,
    output logic        wValid,
    input  wire         wReady,
    output bridgePkg::wordT   wData,
    output bridgePkg::strobeT wStrb,
    input  wire         bValid,
    output logic        bReady
);
    import bridgePkg::*;

    writeStateT state;

    assign awValid = (state == wrAddr);
    assign awAddr  = req.addr;
    assign wValid  = (state == wrData);
    assign wData   = req.wData;
    assign wStrb   = req.strobe;
    assign bReady  = (state == wrResp);

    // the request is released only once the slave has answered
    assign req.writeDone = (state == wrResp) && bValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wrIdle;
        end else begin
            case (state)
                wrIdle: begin
                    if (req.writePending) begin
                        state <= wrAddr;
                    end
                end
                wrAddr: begin
                    if (awReady) begin
                        state <= wrData;
                    end
                end
                wrData: begin
                    if (wReady) begin
                        state <= wrResp;
                    end
                end
                wrResp: begin
                    if (bValid) begin
                        state <= wrIdle;
                    end
                end
                default: state <= wrIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dv/axiSlaveModel.sv
`default_nettype none

module axiSlaveModel (
    input  wire                    clk,
    input  wire                    arValid,
    output logic                   arReady,
    input  wire axiPkg::addrT      arAddr,
    input  wire axiPkg::lenT       arLen,
    output logic                   rValid,
    output bridgePkg::wordT        rData,
    output logic                   rLast,
    input  wire                    rReady,
    input  wire                    awValid,
    output logic                   awReady,
    input  wire axiPkg::addrT      awAddr,
    input  wire                    wValid,
    output logic                   wReady,
    input  wire bridgePkg::wordT   wData,
    input  wire bridgePkg::strobeT wStrb,
    output logic                   bValid,
    input  wire                    bReady
);
    timeunit 1ns;
    timeprecision 100ps;
    import axiPkg::*;
    import bridgePkg::*;

    localparam int    memWords  = 64;
    localparam burstT walkBurst = incrBurst;

    integer seed = 32'ha295644e;
    wordT   mem [memWords];
    logic   rdActive;
    addrT   rdAddr;
    lenT    rdLeft;
    logic   rTaken;
    logic   bTaken;
    logic   awGot;
    logic   wGot;
    addrT   awAddrQ;
    wordT   wDataQ;
    strobeT wStrbQ;

    function automatic wordT fillWord(addrT wordAddr);
        return (wordAddr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic addrT nextBeat(addrT a);
        return (walkBurst == incrBurst) ? a + (addrT'(1) << beatSize) : a;  // a fixed burst stays put
    endfunction

    function automatic logic coin();
        return ($random(seed) & 3) != 0;
    endfunction

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[6'(i)] = fillWord(addrT'(i));
        end
        arReady  = 1'b0;
        rValid   = 1'b0;
        rData    = '0;
        rLast    = 1'b0;
        awReady  = 1'b0;
        wReady   = 1'b0;
        bValid   = 1'b0;
        rdActive = 1'b0;
        rdAddr   = '0;
        rdLeft   = '0;
        rTaken   = 1'b0;
        bTaken   = 1'b0;
        awGot    = 1'b0;
        wGot     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (rTaken) begin
                rValid = 1'b0;
                if (rLast) begin
                    rdActive = 1'b0;
                end else begin
                    rdAddr = nextBeat(rdAddr);
                    rdLeft = rdLeft - 1'b1;
                end
            end
            if (bTaken) begin
                bValid = 1'b0;
            end
            if (rdActive && !rValid && coin()) begin
                rValid = 1'b1;
                rData  = mem[rdAddr[7:2]];
                rLast  = (rdLeft == '0);
            end
            if (awGot && wGot && !bValid && coin()) begin
                for (int b = 0; b < 4; b++) begin
                    if (wStrbQ[b]) mem[awAddrQ[7:2]][8*b +: 8] = wDataQ[8*b +: 8];
                end
                awGot  = 1'b0;
                wGot   = 1'b0;
                bValid = 1'b1;
            end
            arReady = !rdActive && coin();
            awReady = !awGot && coin();
            wReady  = !wGot && coin();
            #2;
            // whatever is seen here transfers on the coming edge
            if (arValid && arReady) begin
                rdActive = 1'b1;
                rdAddr   = arAddr;
                rdLeft   = arLen;
            end
            if (awValid && awReady) begin
                awGot   = 1'b1;
                awAddrQ = awAddr;
            end
            if (wValid && wReady) begin
                wGot   = 1'b1;
                wDataQ = wData;
                wStrbQ = wStrb;
            end
            rTaken = rValid && rReady;
            bTaken = bValid && bReady;
        end
    end

endmodule

`default_nettype wire

//--- dv/bridgeTb.sv
`default_nettype none

module bridgeTb;
    timeunit 1ns;
    timeprecision 100ps;
    import axiPkg::*;
    import bridgePkg::*;

    localparam int memWords  = 64;
    localparam int waitLimit = 200;
    localparam int opCount   = 400;

    integer seed = 32'ha295644e;
    wordT   refMem [memWords];

    logic   clk;
    logic   rst;
    logic   instReqValid;
    addrT   instReqPc;
    logic   instReqReady;
    logic   instRespValid;
    lineT   instRespLine;
    logic   instRespReady;
    logic   dataReqValid;
    addrT   dataReqAddr;
    wordT   dataReqWData;
    logic   dataReqWEn;
    strobeT dataReqStrobe;
    logic   dataReqReady;
    logic   dataRespValid;
    wordT   dataRespData;
    logic   dataRespReady;
    logic   arValid;
    logic   arReady;
    idT     arId;
    addrT   arAddr;
    lenT    arLen;
    logic   rValid;
    wordT   rData;
    logic   rLast;
    logic   rReady;
    logic   awValid;
    logic   awReady;
    addrT   awAddr;
    logic   wValid;
    logic   wReady;
    wordT   wData;
    strobeT wStrb;
    logic   bValid;
    logic   bReady;

    axiBridge axiBridge_inst (
        .clk           (clk),
        .rst           (rst),
        .instReqValid  (instReqValid),
        .instReqPc     (instReqPc),
        .instReqReady  (instReqReady),
        .instRespValid (instRespValid),
        .instRespLine  (instRespLine),
        .instRespReady (instRespReady),
        .dataReqValid  (dataReqValid),
        .dataReqAddr   (dataReqAddr),
        .dataReqWData  (dataReqWData),
        .dataReqWEn    (dataReqWEn),
        .dataReqStrobe (dataReqStrobe),
        .dataReqReady  (dataReqReady),
        .dataRespValid (dataRespValid),
        .dataRespData  (dataRespData),
        .dataRespReady (dataRespReady),
        .arValid       (arValid),
        .arReady       (arReady),
        .arId          (arId),
        .arAddr        (arAddr),
        .arLen         (arLen),
        .rValid        (rValid),
        .rData         (rData),
        .rLast         (rLast),
        .rReady        (rReady),
        .awValid       (awValid),
        .awReady       (awReady),
        .awAddr        (awAddr),
        .wValid        (wValid),
        .wReady        (wReady),
        .wData         (wData),
        .wStrb         (wStrb),
        .bValid        (bValid),
        .bReady        (bReady)
    );

    axiSlaveModel slaveModel (
        .clk     (clk),
        .arValid (arValid),
        .arReady (arReady),
        .arAddr  (arAddr),
        .arLen   (arLen),
        .rValid  (rValid),
        .rData   (rData),
        .rLast   (rLast),
        .rReady  (rReady),
        .awValid (awValid),
        .awReady (awReady),
        .awAddr  (awAddr),
        .wValid  (wValid),
        .wReady  (wReady),
        .wData   (wData),
        .wStrb   (wStrb),
        .bValid  (bValid),
        .bReady  (bReady)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // response readies drop at random to exercise back-pressure
    initial begin
        instRespReady = 1'b0;
        dataRespReady = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            instRespReady = ($random(seed) & 1) != 0;
            dataRespReady = ($random(seed) & 1) != 0;
        end
    end

    function automatic wordT fillWord(addrT wordAddr);
        return (wordAddr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic lineT refLine(addrT pc);
        logic [5:0] base;
        base = pc[7:2] & 6'h3c;
        return {refMem[base + 6'd3], refMem[base + 6'd2], refMem[base + 6'd1], refMem[base]};
    endfunction

    task automatic stopRun();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic compareWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic compareLine(string name, lineT got, lineT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic compareAddr(string name, addrT got, addrT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic compareId(string name, idT got, idT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic compareLen(string name, lenT got, lenT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic compareStrobe(string name, strobeT got, strobeT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    // steps to the sample point of the next cycle, where everything has settled
    task automatic tick(string what, inout int n);
        n++;
        if (n > waitLimit) begin
            $display("no %s within %0d cycles", what, waitLimit);
            stopRun();
        end
        @(posedge clk);
        #3;
    endtask

    task automatic checkIdle();
        compareBit("arValid", arValid, 1'b0);
        compareBit("rReady", rReady, 1'b0);
        compareBit("awValid", awValid, 1'b0);
        compareBit("wValid", wValid, 1'b0);
        compareBit("bReady", bReady, 1'b0);
        compareBit("instRespValid", instRespValid, 1'b0);
        compareBit("dataRespValid", dataRespValid, 1'b0);
        compareBit("instReqReady", instReqReady, 1'b1);
        compareBit("dataReqReady", dataReqReady, 1'b1);
    endtask

    task automatic sendData(addrT addr, wordT wdata, logic wen, strobeT strobe);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        dataReqValid  = 1'b1;
        dataReqAddr   = addr;
        dataReqWData  = wdata;
        dataReqWEn    = wen;
        dataReqStrobe = strobe;
        #2;
        while (!dataReqReady) tick("data request accept", n);
        @(posedge clk);
        #1;
        dataReqValid = 1'b0;
        #2;
    endtask

    task automatic sendInst(addrT pc);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        instReqValid = 1'b1;
        instReqPc    = pc;
        #2;
        while (!instReqReady) tick("instruction request accept", n);
        @(posedge clk);
        #1;
        instReqValid = 1'b0;
        #2;
    endtask

    task automatic waitAr(idT id, lenT len, addrT addr);
        int n;
        n = 0;
        while (!(arValid && arReady)) tick("AR transfer", n);
        compareId("arId", arId, id);
        compareLen("arLen", arLen, len);
        compareAddr("arAddr", arAddr, addr);
    endtask

    task automatic takeWord(output wordT word);
        int   n;
        logic seen;
        wordT held;
        n    = 0;
        seen = 1'b0;
        held = '0;
        while (!(dataRespValid && dataRespReady)) begin
            if (seen) begin
                compareBit("dataRespValid", dataRespValid, 1'b1);
                compareWord("dataRespData", dataRespData, held);
            end
            if (dataRespValid) begin
                seen = 1'b1;
                held = dataRespData;
            end
            tick("data response", n);
        end
        if (seen) compareWord("dataRespData", dataRespData, held);
        word = dataRespData;
    endtask

    task automatic takeLine(output lineT line);
        int   n;
        logic seen;
        lineT held;
        n    = 0;
        seen = 1'b0;
        held = '0;
        while (!(instRespValid && instRespReady)) begin
            if (seen) begin
                compareBit("instRespValid", instRespValid, 1'b1);
                compareLine("instRespLine", instRespLine, held);
            end
            if (instRespValid) begin
                seen = 1'b1;
                held = instRespLine;
            end
            tick("instruction response", n);
        end
        if (seen) compareLine("instRespLine", instRespLine, held);
        line = instRespLine;
    endtask

    task automatic fetchLine(addrT pc);
        lineT line;
        sendInst(pc);
        waitAr(instId, lineLen, {pc[31:4], 4'h0});
        takeLine(line);
        compareLine("instRespLine", line, refLine(pc));
    endtask

    task automatic readWord(addrT addr);
        wordT word;
        sendData(addr, '0, 1'b0, '0);
        waitAr(dataId, singleLen, addr);
        takeWord(word);
        compareWord("dataRespData", word, refMem[addr[7:2]]);
    endtask

    task automatic writeWord(addrT addr, wordT wdata, strobeT strobe);
        int n;
        sendData(addr, wdata, 1'b1, strobe);
        n = 0;
        while (!(awValid && awReady)) tick("AW transfer", n);
        compareAddr("awAddr", awAddr, addr);
        n = 0;
        while (!(wValid && wReady)) tick("W transfer", n);
        compareWord("wData", wData, wdata);
        compareStrobe("wStrb", wStrb, strobe);
        n = 0;
        while (!dataReqReady) tick("write completion", n);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) refMem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
        end
    endtask

    // both requests land in the same cycle, so the data read must win arbitration
    task automatic fetchWithRead(addrT pc, addrT addr);
        int   n;
        wordT word;
        lineT line;
        n = 0;
        while (!(instReqReady && dataReqReady)) tick("both request readies", n);
        @(posedge clk);
        #1;
        instReqValid = 1'b1;
        instReqPc    = pc;
        dataReqValid = 1'b1;
        dataReqAddr  = addr;
        dataReqWEn   = 1'b0;
        #2;
        compareBit("instReqReady", instReqReady, 1'b1);
        compareBit("dataReqReady", dataReqReady, 1'b1);
        @(posedge clk);
        #1;
        instReqValid = 1'b0;
        dataReqValid = 1'b0;
        #2;
        waitAr(dataId, singleLen, addr);
        takeWord(word);
        compareWord("dataRespData", word, refMem[addr[7:2]]);
        waitAr(instId, lineLen, {pc[31:4], 4'h0});
        takeLine(line);
        compareLine("instRespLine", line, refLine(pc));
    endtask

    initial begin
        addrT   addr;
        addrT   pc;
        wordT   wdata;
        strobeT strobe;
        rst           = 1'b1;
        instReqValid  = 1'b0;
        instReqPc     = '0;
        dataReqValid  = 1'b0;
        dataReqAddr   = '0;
        dataReqWData  = '0;
        dataReqWEn    = 1'b0;
        dataReqStrobe = '0;
        for (int i = 0; i < memWords; i++) begin
            refMem[6'(i)] = fillWord(addrT'(i));
        end
        @(posedge clk);
        #3;
        checkIdle();
        @(posedge clk);
        #1;
        rst = 1'b0;
        #2;
        checkIdle();
        @(posedge clk);
        #3;
        checkIdle();
        for (int i = 0; i < opCount; i++) begin
            addr   = {24'h0, 6'($random(seed)), 2'b00};
            pc     = {24'h0, 6'($random(seed)), 2'b00};
            wdata  = $random(seed);
            strobe = 4'($random(seed));
            case ($random(seed) & 3)
                0: fetchLine(pc);
                1: readWord(addr);
                2: begin
                    writeWord(addr, wdata, strobe);
                    readWord(addr);  // reads back the strobe-merged word
                end
                default: fetchWithRead(pc, addr);
            endcase
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
common/axiPkg.sv
common/bridgePkg.sv
common/dataReqIf.sv
design/dataReqSlot.sv
design/readEngine.sv
design/writeEngine.sv
design/axiBridge.sv
dv/axiSlaveModel.sv
dv/bridgeTb.sv
